// ==== source/mshr_pkg.sv ====
// MSHR shared definitions
`default_nettype none

package mshr_pkg;

    // ====================================================================
    // Block geometry
    // ====================================================================

    // Bytes per cache block
    localparam int BLOCK_BYTES = 8;

    // Block width in bits
    localparam int BLOCK_W = BLOCK_BYTES * 8;

    // Offset bits inside one block
    localparam int OFFSET_W = $clog2(BLOCK_BYTES);

    // Processor data width
    localparam int DATA_W = 64;

    // ====================================================================
    // Encodings
    // ====================================================================

    // Processor command
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_LOAD  = 2'd1,
        CMD_STORE = 2'd2
    } proc_cmd_e;

    // Access size, one lane group per size
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_e;

    // Entry phases, one per handshake
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_REFILL = 3'd1,
        ST_UPDATE = 3'd2,
        ST_OUTPUT = 3'd3,
        ST_EVICT  = 3'd4,
        ST_DONE   = 3'd5
    } mshr_state_e;

endpackage

`default_nettype wire

// ==== source/mshr_mem_if.sv ====
// MSHR block transfer channel
`timescale 1ns/1ps
`default_nettype none

interface mshr_mem_if #(
    parameter int ADDR_W = 32
) ();
    import mshr_pkg::*;

    // Request side, held steady by the entry until done
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [BLOCK_W-1:0] wdata;

    // Completion side, rdata valid with the done pulse
    logic [BLOCK_W-1:0] rdata;
    logic              done;

    modport fsm (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport master (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

`default_nettype wire

// ==== source/mshr_lane_align.sv ====
// Byte lane merge and extract
`timescale 1ns/1ps
`default_nettype none

module mshr_lane_align (
    input  mshr_pkg::mem_size_e                size_i,
    input  logic [mshr_pkg::OFFSET_W-1:0]      offset_i,
    input  logic [mshr_pkg::BLOCK_W-1:0]       block_i,
    input  logic [mshr_pkg::DATA_W-1:0]        store_data_i,
    output logic [mshr_pkg::BLOCK_W-1:0]       merged_o,
    output logic [mshr_pkg::DATA_W-1:0]        load_data_o
);
    import mshr_pkg::*;

    // Bit position of the lowest lane
    localparam int SHIFT_W = OFFSET_W + 3;

    localparam logic [BLOCK_W-1:0] BYTE_MASK = BLOCK_W'(8'hff);
    localparam logic [BLOCK_W-1:0] HALF_MASK = BLOCK_W'(16'hffff);
    localparam logic [BLOCK_W-1:0] WORD_MASK = BLOCK_W'(32'hffff_ffff);

    logic [SHIFT_W-1:0] bit_shift;
    logic [BLOCK_W-1:0] field_mask;
    logic [BLOCK_W-1:0] lane_mask;
    logic [BLOCK_W-1:0] store_lanes;

    // ====================================================================
    // Lane selection
    // ====================================================================

    // Offset bits below the access size are dropped
    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                bit_shift  = {offset_i, 3'b000};
                field_mask = BYTE_MASK;
            end
            SIZE_HALF: begin
                bit_shift  = {offset_i[OFFSET_W-1:1], 4'b0000};
                field_mask = HALF_MASK;
            end
            SIZE_WORD: begin
                bit_shift  = {offset_i[OFFSET_W-1:2], 5'b00000};
                field_mask = WORD_MASK;
            end
            default: begin
                // Double covers the whole block
                bit_shift  = '0;
                field_mask = {BLOCK_W{1'b1}};
            end
        endcase
    end

    // ====================================================================
    // Merge and extract
    // ====================================================================

    assign lane_mask   = field_mask << bit_shift;
    assign store_lanes = (BLOCK_W'(store_data_i) & field_mask) << bit_shift;

    // Store data replaces only the selected lanes
    assign merged_o = (block_i & ~lane_mask) | store_lanes;

    // Selected lanes moved down, upper bits zero
    assign load_data_o = DATA_W'((block_i >> bit_shift) & field_mask);

endmodule

`default_nettype wire

// ==== source/mshr_wb_master.sv ====
// Wishbone classic block master
`timescale 1ns/1ps
`default_nettype none

module mshr_wb_master #(
    parameter int ADDR_W = 32
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    mshr_mem_if.master                         mem,
    output logic                               wb_cyc_o,
    output logic                               wb_stb_o,
    output logic                               wb_we_o,
    output logic [ADDR_W-1:0]                  wb_adr_o,
    output logic [mshr_pkg::BLOCK_BYTES-1:0]   wb_sel_o,
    output logic [mshr_pkg::BLOCK_W-1:0]       wb_dat_o,
    input  logic [mshr_pkg::BLOCK_W-1:0]       wb_dat_i,
    input  logic                               wb_ack_i
);

    logic start;
    logic finish;

    // A held request is not restarted while its done pulse is out
    assign start  = mem.req && !wb_cyc_o && !mem.done;
    assign finish = wb_cyc_o && wb_ack_i;

    // ====================================================================
    // Bus cycle control
    // ====================================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (start) begin
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
                wb_we_o  <= mem.we;
            end else if (finish) begin
                // Classic cycle ends the cycle after ack
                wb_cyc_o <= 1'b0;
                wb_stb_o <= 1'b0;
                wb_we_o  <= 1'b0;
                mem.done <= 1'b1;
            end
        end
    end

    // ====================================================================
    // Address and data
    // ====================================================================

    always_ff @(posedge clk_i) begin
        if (start) begin
            wb_adr_o <= mem.addr;
            wb_dat_o <= mem.wdata;
        end
        // Read data lines up with the done pulse
        if (finish) begin
            mem.rdata <= wb_dat_i;
        end
    end

    // Whole block every transfer
    assign wb_sel_o = '1;

endmodule

`default_nettype wire

// ==== source/mshr_entry_fsm.sv ====
// MSHR entry state machine
`timescale 1ns/1ps
`default_nettype none

module mshr_entry_fsm #(
    parameter int ADDR_W = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Processor request and response
    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  mshr_pkg::proc_cmd_e             req_cmd_i,
    input  logic [ADDR_W-1:0]               req_addr_i,
    input  mshr_pkg::mem_size_e             req_size_i,
    input  logic [mshr_pkg::DATA_W-1:0]     req_wdata_i,
    output logic                            resp_valid_o,
    input  logic                            resp_ready_i,
    output logic [mshr_pkg::DATA_W-1:0]     resp_data_o,
    // Cache fill and victim
    output logic                            fill_valid_o,
    input  logic                            fill_grant_i,
    output logic [ADDR_W-1:0]               fill_addr_o,
    output logic [mshr_pkg::BLOCK_W-1:0]    fill_data_o,
    input  logic [ADDR_W-1:0]               victim_addr_i,
    input  logic [mshr_pkg::BLOCK_W-1:0]    victim_data_i,
    input  logic                            victim_dirty_i,
    // Completion and memory side
    output logic                            done_o,
    mshr_mem_if.fsm                         mem
);
    import mshr_pkg::*;

    mshr_state_e        state_q;
    mshr_state_e        state_d;

    // Entry registers
    proc_cmd_e          cmd_q;
    logic [ADDR_W-1:0]  addr_q;
    mem_size_e          size_q;
    logic [DATA_W-1:0]  wdata_q;
    logic [BLOCK_W-1:0] block_q;
    logic [ADDR_W-1:0]  victim_addr_q;
    logic [BLOCK_W-1:0] victim_data_q;
    logic               victim_dirty_q;

    logic [BLOCK_W-1:0] lane_block;
    logic [BLOCK_W-1:0] merged_block;

    // ====================================================================
    // Next state
    // ====================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i && req_cmd_i != CMD_NONE) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem.done) begin
                    state_d = ST_UPDATE;
                end
            end
            ST_UPDATE: begin
                if (fill_grant_i) begin
                    if (cmd_q == CMD_LOAD) begin
                        state_d = ST_OUTPUT;
                    end else if (victim_dirty_i) begin
                        state_d = ST_EVICT;
                    end else begin
                        state_d = ST_DONE;
                    end
                end
            end
            ST_OUTPUT: begin
                if (resp_ready_i) begin
                    state_d = victim_dirty_q ? ST_EVICT : ST_DONE;
                end
            end
            ST_EVICT: begin
                if (mem.done) begin
                    state_d = ST_DONE;
                end
            end
            default: begin
                // Done lasts one cycle
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ====================================================================
    // Entry registers
    // ====================================================================

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && req_valid_i) begin
            cmd_q   <= req_cmd_i;
            addr_q  <= req_addr_i;
            size_q  <= req_size_i;
            wdata_q <= req_wdata_i;
        end
        // Loads keep the refilled block as it came from memory
        if (state_q == ST_REFILL && mem.done) begin
            block_q <= (cmd_q == CMD_STORE) ? merged_block : mem.rdata;
        end
        if (state_q == ST_UPDATE && fill_grant_i) begin
            victim_addr_q  <= victim_addr_i;
            victim_data_q  <= victim_data_i;
            victim_dirty_q <= victim_dirty_i;
        end
    end

    // Merge works on the incoming block, extraction on the stored one
    assign lane_block = (state_q == ST_REFILL) ? mem.rdata : block_q;

    mshr_lane_align u_lane (
        .size_i       (size_q),
        .offset_i     (addr_q[OFFSET_W-1:0]),
        .block_i      (lane_block),
        .store_data_i (wdata_q),
        .merged_o     (merged_block),
        .load_data_o  (resp_data_o)
    );

    // ====================================================================
    // Outputs
    // ====================================================================

    assign req_ready_o  = (state_q == ST_IDLE);
    assign fill_valid_o = (state_q == ST_UPDATE);
    assign fill_addr_o  = addr_q;
    assign fill_data_o  = block_q;
    assign resp_valid_o = (state_q == ST_OUTPUT);
    assign done_o       = (state_q == ST_DONE);

    // Block reads for refill, block writes for the dirty victim
    assign mem.req   = (state_q == ST_REFILL) || (state_q == ST_EVICT);
    assign mem.we    = (state_q == ST_EVICT);
    assign mem.addr  = (state_q == ST_EVICT)
                     ? {victim_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}
                     : {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem.wdata = victim_data_q;

endmodule

`default_nettype wire

// ==== source/mshr_top.sv ====
// MSHR entry top level
`timescale 1ns/1ps
`default_nettype none

module mshr_top #(
    parameter int ADDR_W = 32
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    // Processor port
    input  logic                               req_valid_i,
    output logic                               req_ready_o,
    input  mshr_pkg::proc_cmd_e                req_cmd_i,
    input  logic [ADDR_W-1:0]                  req_addr_i,
    input  mshr_pkg::mem_size_e                req_size_i,
    input  logic [mshr_pkg::DATA_W-1:0]        req_wdata_i,
    output logic                               resp_valid_o,
    input  logic                               resp_ready_i,
    output logic [mshr_pkg::DATA_W-1:0]        resp_data_o,
    // Cache fill port
    output logic                               fill_valid_o,
    input  logic                               fill_grant_i,
    output logic [ADDR_W-1:0]                  fill_addr_o,
    output logic [mshr_pkg::BLOCK_W-1:0]       fill_data_o,
    input  logic [ADDR_W-1:0]                  victim_addr_i,
    input  logic [mshr_pkg::BLOCK_W-1:0]       victim_data_i,
    input  logic                               victim_dirty_i,
    output logic                               done_o,
    // Wishbone master port
    output logic                               wb_cyc_o,
    output logic                               wb_stb_o,
    output logic                               wb_we_o,
    output logic [ADDR_W-1:0]                  wb_adr_o,
    output logic [mshr_pkg::BLOCK_BYTES-1:0]   wb_sel_o,
    output logic [mshr_pkg::BLOCK_W-1:0]       wb_dat_o,
    input  logic [mshr_pkg::BLOCK_W-1:0]       wb_dat_i,
    input  logic                               wb_ack_i
);

    // Block transfers between the entry and the bus
    mshr_mem_if #(.ADDR_W(ADDR_W)) mem_if ();

    mshr_entry_fsm #(.ADDR_W(ADDR_W)) u_entry (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_cmd_i      (req_cmd_i),
        .req_addr_i     (req_addr_i),
        .req_size_i     (req_size_i),
        .req_wdata_i    (req_wdata_i),
        .resp_valid_o   (resp_valid_o),
        .resp_ready_i   (resp_ready_i),
        .resp_data_o    (resp_data_o),
        .fill_valid_o   (fill_valid_o),
        .fill_grant_i   (fill_grant_i),
        .fill_addr_o    (fill_addr_o),
        .fill_data_o    (fill_data_o),
        .victim_addr_i  (victim_addr_i),
        .victim_data_i  (victim_data_i),
        .victim_dirty_i (victim_dirty_i),
        .done_o         (done_o),
        .mem            (mem_if.fsm)
    );

    mshr_wb_master #(.ADDR_W(ADDR_W)) u_wb (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .mem      (mem_if.master),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

endmodule

`default_nettype wire

// ==== verif/tb_wb_mem.sv ====
// Wishbone slave memory model
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [63:0] wb_dat_i,
    output logic [63:0] wb_dat_o,
    output logic        wb_ack_o,
    // Transfer log
    output logic [31:0] read_count_o,
    output logic [31:0] write_count_o,
    output logic [31:0] last_read_adr_o,
    output logic [31:0] last_write_adr_o,
    output logic [63:0] last_write_dat_o
);

    logic        ack_q      = 1'b0;
    logic [63:0] rdata_q    = '0;
    logic [31:0] rd_cnt_q   = '0;
    logic [31:0] wr_cnt_q   = '0;
    logic [31:0] rd_adr_q   = '0;
    logic [31:0] wr_adr_q   = '0;
    logic [63:0] wr_dat_q   = '0;
    logic        busy       = 1'b0;
    logic [1:0]  wait_cnt   = 2'd0;
    logic [31:0] delay_seed = 32'h290a;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Block contents depend on every address bit
    function automatic logic [63:0] block_pattern(input logic [31:0] blk_adr);
        logic [31:0] hi;
        hi = lcg_next(lcg_next(32'h290a ^ blk_adr));
        return {hi, lcg_next(hi)};
    endfunction

    // Responses change on the falling edge only
    always @(negedge clk_i) begin
        if (rst_i) begin
            ack_q = 1'b0;
            busy  = 1'b0;
        end else if (ack_q) begin
            // Ack lasts one cycle
            ack_q = 1'b0;
            busy  = 1'b0;
        end else if (wb_cyc_i && wb_stb_i) begin
            if (!busy) begin
                busy       = 1'b1;
                delay_seed = lcg_next(delay_seed);
                wait_cnt   = delay_seed[17:16];
            end
            if (wait_cnt == 2'd0) begin
                ack_q = 1'b1;
                if (wb_we_i) begin
                    wr_cnt_q = wr_cnt_q + 32'd1;
                    wr_adr_q = wb_adr_i;
                    wr_dat_q = wb_dat_i;
                end else begin
                    rd_cnt_q = rd_cnt_q + 32'd1;
                    rd_adr_q = wb_adr_i;
                    rdata_q  = block_pattern(wb_adr_i);
                end
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

    assign wb_ack_o         = ack_q;
    assign wb_dat_o         = rdata_q;
    assign read_count_o     = rd_cnt_q;
    assign write_count_o    = wr_cnt_q;
    assign last_read_adr_o  = rd_adr_q;
    assign last_write_adr_o = wr_adr_q;
    assign last_write_dat_o = wr_dat_q;

endmodule

`default_nettype wire

// ==== verif/tb_mshr.sv ====
// MSHR entry testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mshr;
    import mshr_pkg::*;

    localparam int ADDR_W   = 32;
    localparam int NUM_ROWS = 12;

    typedef struct packed {
        proc_cmd_e   cmd;
        logic [31:0] addr;
        mem_size_e   size;
        logic [63:0] wdata;
        logic [31:0] vaddr;
        logic [63:0] vdata;
        logic        vdirty;
    } row_t;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        req_valid = 1'b0;
    logic        req_ready;
    proc_cmd_e   req_cmd = CMD_NONE;
    logic [31:0] req_addr = '0;
    mem_size_e   req_size = SIZE_BYTE;
    logic [63:0] req_wdata = '0;
    logic        resp_valid;
    logic        resp_ready = 1'b0;
    logic [63:0] resp_data;
    logic        fill_valid;
    logic        fill_grant = 1'b0;
    logic [31:0] fill_addr;
    logic [63:0] fill_data;
    logic [31:0] victim_addr = '0;
    logic [63:0] victim_data = '0;
    logic        victim_dirty = 1'b0;
    logic        done;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_ack;
    logic [31:0] wb_adr;
    logic [7:0]  wb_sel;
    logic [63:0] wb_wdata;
    logic [63:0] wb_rdata;
    logic [31:0] rd_count;
    logic [31:0] wr_count;
    logic [31:0] last_rd_adr;
    logic [31:0] last_wr_adr;
    logic [63:0] last_wr_dat;

    row_t        rows[$];
    row_t        cur;
    int          errors = 0;
    int          checks = 0;
    // Handshake counters kept by the monitor
    int          fill_cnt = 0;
    int          resp_cnt = 0;
    int          done_cnt = 0;
    int          order_bad = 0;
    int          sel_bad = 0;
    int          stb_bad = 0;
    int          fill_base = 0;
    int          resp_base = 0;
    logic [31:0] fill_addr_seen = '0;
    logic [63:0] fill_data_seen = '0;
    logic [63:0] resp_data_seen = '0;
    logic [31:0] rand_state = 32'h290a;
    logic [1:0]  grant_wait = 2'd0;
    logic [1:0]  resp_wait = 2'd0;

    mshr_top #(.ADDR_W(ADDR_W)) u_dut (
        .clk_i(clk), .rst_i(rst),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_cmd_i(req_cmd),
        .req_addr_i(req_addr), .req_size_i(req_size), .req_wdata_i(req_wdata),
        .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_data_o(resp_data),
        .fill_valid_o(fill_valid), .fill_grant_i(fill_grant), .fill_addr_o(fill_addr),
        .fill_data_o(fill_data), .victim_addr_i(victim_addr), .victim_data_i(victim_data),
        .victim_dirty_i(victim_dirty), .done_o(done),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_sel_o(wb_sel), .wb_dat_o(wb_wdata), .wb_dat_i(wb_rdata), .wb_ack_i(wb_ack)
    );

    tb_wb_mem u_mem (
        .clk_i(clk), .rst_i(rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_wdata), .wb_dat_o(wb_rdata), .wb_ack_o(wb_ack),
        .read_count_o(rd_count), .write_count_o(wr_count), .last_read_adr_o(last_rd_adr),
        .last_write_adr_o(last_wr_adr), .last_write_dat_o(last_wr_dat)
    );

    // ===================================================================
    // Reference model
    // ===================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] block_pattern(input logic [31:0] blk_adr);
        logic [31:0] hi;
        hi = lcg_next(lcg_next(32'h290a ^ blk_adr));
        return {hi, lcg_next(hi)};
    endfunction

    // Lanes start at the offset rounded down to the access size
    function automatic logic [63:0] expect_merge(input logic [63:0] blk, input mem_size_e size,
                                                 input int offset, input logic [63:0] data);
        int nbytes;
        int base;
        logic [63:0] r;
        nbytes = 1 << size;
        base = (offset / nbytes) * nbytes;
        r = blk;
        for (int b = 0; b < nbytes; b++) begin
            r[(base + b) * 8 +: 8] = data[b * 8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [63:0] expect_load(input logic [63:0] blk, input mem_size_e size,
                                                input int offset);
        int nbytes;
        int base;
        logic [63:0] r;
        nbytes = 1 << size;
        base = (offset / nbytes) * nbytes;
        r = '0;
        for (int b = 0; b < nbytes; b++) begin
            r[b * 8 +: 8] = blk[(base + b) * 8 +: 8];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic void add_row(input proc_cmd_e cmd, input logic [31:0] addr,
                                    input mem_size_e size, input logic [63:0] wdata,
                                    input logic [31:0] vaddr, input logic dirty);
        rows.push_back('{cmd, addr, size, wdata, vaddr, {~vaddr, vaddr}, dirty});
    endfunction

    // ===================================================================
    // Clock, cache model, monitor and watchdog
    // ===================================================================

    initial begin
        forever #2 clk = ~clk;
    end

    // Grant and resp_ready come after a random delay, one cycle each
    always @(negedge clk) begin
        fill_grant = 1'b0;
        resp_ready = 1'b0;
        if (fill_valid) begin
            if (grant_wait == 2'd0) begin
                fill_grant = 1'b1;
                rand_state = lcg_next(rand_state);
                grant_wait = rand_state[17:16];
            end else begin
                grant_wait = grant_wait - 2'd1;
            end
        end
        if (resp_valid) begin
            if (resp_wait == 2'd0) begin
                resp_ready = 1'b1;
                rand_state = lcg_next(rand_state);
                resp_wait = rand_state[17:16];
            end else begin
                resp_wait = resp_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (fill_valid && fill_grant) begin
                fill_cnt = fill_cnt + 1;
                fill_addr_seen = fill_addr;
                fill_data_seen = fill_data;
            end
            if (resp_valid && resp_ready) begin
                resp_cnt = resp_cnt + 1;
                resp_data_seen = resp_data;
            end
            // Classic cycles raise and drop the strobe with the cycle
            if (wb_stb !== wb_cyc) begin
                stb_bad = stb_bad + 1;
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                if (wb_sel != 8'hff) begin
                    sel_bad = sel_bad + 1;
                end
                // Write-back must follow the fill, and the response for loads
                if (wb_we && (fill_cnt == fill_base
                              || (cur.cmd == CMD_LOAD && resp_cnt == resp_base))) begin
                    order_bad = order_bad + 1;
                end
            end
            if (done) begin
                done_cnt = done_cnt + 1;
            end
        end
    end

    initial begin
        repeat (NUM_ROWS * 200 + 20) @(posedge clk);
        $display("Timeout: the rows did not complete within %0d cycles", NUM_ROWS * 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ===================================================================
    // Stimulus
    // ===================================================================

    task automatic run_row(input row_t r, input int idx);
        logic [31:0] blk_adr;
        logic [63:0] blk;
        logic [63:0] exp_fill;
        logic [31:0] rd_base;
        logic [31:0] wr_base;
        int offset;
        int done_base;
        int order_base;
        blk_adr = {r.addr[31:3], 3'b000};
        blk = block_pattern(blk_adr);
        offset = int'(r.addr[2:0]);
        exp_fill = (r.cmd == CMD_STORE) ? expect_merge(blk, r.size, offset, r.wdata) : blk;
        cur = r;
        fill_base = fill_cnt;
        resp_base = resp_cnt;
        done_base = done_cnt;
        order_base = order_bad;
        rd_base = rd_count;
        wr_base = wr_count;
        @(negedge clk);
        req_valid = 1'b1;
        req_cmd = r.cmd;
        req_addr = r.addr;
        req_size = r.size;
        req_wdata = r.wdata;
        victim_addr = r.vaddr;
        victim_data = r.vdata;
        victim_dirty = r.vdirty;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        req_cmd = CMD_NONE;
        wait (done_cnt != done_base);
        @(negedge clk);
        check_value("req_ready_o", 64'(req_ready), 64'd1);
        check_value("wb read count", 64'(rd_count - rd_base), 64'd1);
        check_value("wb_adr_o read", 64'(last_rd_adr), 64'(blk_adr));
        check_value("fill grant count", 64'(fill_cnt - fill_base), 64'd1);
        check_value("fill_addr_o", 64'(fill_addr_seen), 64'(r.addr));
        check_value("fill_data_o", fill_data_seen, exp_fill);
        check_value("resp count", 64'(resp_cnt - resp_base),
                    (r.cmd == CMD_LOAD) ? 64'd1 : 64'd0);
        if (r.cmd == CMD_LOAD) begin
            check_value("resp_data_o", resp_data_seen, expect_load(blk, r.size, offset));
        end
        check_value("wb write count", 64'(wr_count - wr_base), 64'(r.vdirty));
        if (r.vdirty) begin
            check_value("wb_adr_o write", 64'(last_wr_adr), 64'({r.vaddr[31:3], 3'b000}));
            check_value("wb_dat_o write", last_wr_dat, r.vdata);
        end
        if (order_bad != order_base) begin
            errors = errors + 1;
            $display("Row %0d: victim write-back came before the fill or the response", idx);
        end
        // A stretched done pulse is counted on the following edge
        @(negedge clk);
        check_value("done_o pulses", 64'(done_cnt - done_base), 64'd1);
    endtask

    initial begin
        int i;
        // Load rows cover every size, then stores, dirty and clean victims mixed
        add_row(CMD_LOAD, 32'h1000, SIZE_BYTE, 64'h0, 32'h9000, 1'b0);
        add_row(CMD_LOAD, 32'h1007, SIZE_BYTE, 64'h0, 32'h9105, 1'b1);
        add_row(CMD_LOAD, 32'h2002, SIZE_HALF, 64'h0, 32'h9200, 1'b0);
        add_row(CMD_LOAD, 32'h2017, SIZE_HALF, 64'h0, 32'h930e, 1'b1);
        add_row(CMD_LOAD, 32'h3004, SIZE_WORD, 64'h0, 32'h9400, 1'b0);
        add_row(CMD_LOAD, 32'h3043, SIZE_WORD, 64'h0, 32'h9507, 1'b1);
        add_row(CMD_LOAD, 32'h4008, SIZE_DOUBLE, 64'h0, 32'h9600, 1'b0);
        add_row(CMD_STORE, 32'h5005, SIZE_BYTE, 64'hffff_ffff_ffff_ffa5, 32'ha001, 1'b1);
        add_row(CMD_STORE, 32'h5106, SIZE_HALF, 64'h0000_0000_0000_beef, 32'ha100, 1'b0);
        add_row(CMD_STORE, 32'h6001, SIZE_WORD, 64'h1234_5678_cafe_f00d, 32'hb003, 1'b1);
        add_row(CMD_STORE, 32'h6204, SIZE_WORD, 64'h0, 32'hb200, 1'b0);
        add_row(CMD_STORE, 32'h7000, SIZE_DOUBLE, 64'hfedc_ba98_7654_3210, 32'hc00f, 1'b1);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("req_ready_o", 64'(req_ready), 64'd1);
        check_value("resp_valid_o", 64'(resp_valid), 64'd0);
        check_value("fill_valid_o", 64'(fill_valid), 64'd0);
        check_value("done_o", 64'(done), 64'd0);
        check_value("wb_cyc_o", 64'(wb_cyc), 64'd0);
        check_value("wb_stb_o", 64'(wb_stb), 64'd0);
        check_value("wb_we_o", 64'(wb_we), 64'd0);
        for (i = 0; i < rows.size(); i++) begin
            run_row(rows[i], i);
        end
        check_value("wb_sel_o partial cycles", 64'(sel_bad), 64'd0);
        check_value("wb_stb_o cycles apart from wb_cyc_o", 64'(stb_bad), 64'd0);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/mshr_pkg.sv
source/mshr_mem_if.sv
source/mshr_lane_align.sv
source/mshr_wb_master.sv
source/mshr_entry_fsm.sv
source/mshr_top.sv
verif/tb_wb_mem.sv
verif/tb_mshr.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MSHR testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Simulation finished: FAIL"

if ! verilator --binary --timing -f src.f --top-module tb_mshr -Mdir obj_dir -o sim_mshr; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mshr > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG"; then
    exit 1
fi
exit 0
